/* compile.f */
+incdir+test
hw/bitmap_pkg.sv
hw/line_ram.sv
hw/fetch_addr_gen.sv
hw/fetch_word_writer.sv
hw/line_buffer.sv
hw/pixel_decoder.sv
hw/bitmap_layer.sv
test/bitmap_layer_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build the bitmap layer testbench with Verilator, run it, and judge the log
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f compile.f --top-module bitmap_layer_tb \
    -o bitmap_sim \
    && ./obj_dir/bitmap_sim | tee sim.log \
    || { echo "Build or run of the simulation failed"; exit 1; }

grep -qx "sim passed" sim.log \
    && echo "Result: PASS" \
    || { echo "Result: FAIL"; exit 1; }

/* test/bitmap_tb_cases.svh */
`ifndef BITMAP_TB_CASES_SVH
`define BITMAP_TB_CASES_SVH

// Columns: {colour mode, width, palette mode, plt offset}, x, y, expected byte address,
// then a mask of fetched words forced to zero (bit i is word i in fetch order)
function automatic case_t table_row(int r);
    case_t t;
    case (r)
        0:  t = '{'{clrm_2bpp, ximm_256, pltm_palette, 4'h5},
                  11'd37, 13'd10, 19'h00288, 16'h0001};
        1:  t = '{'{clrm_2bpp, ximm_2048, pltm_palette, 4'hA},
                  11'd1500, 13'd5000, 19'h71174, 16'h0000};        // Y wraps
        2:  t = '{'{clrm_4bpp, ximm_512, pltm_palette, 4'hC},
                  11'd700, 13'd300, 19'h12C5C, 16'h0004};          // X past the width
        3:  t = '{'{clrm_4bpp, ximm_1024, pltm_palette, 4'h3},
                  11'd1023, 13'd8191, 19'h7FFFC, 16'h0000};
        4:  t = '{'{clrm_8bpp, ximm_256, pltm_palette, 4'h9},
                  11'd255, 13'd1000, 19'h3E8FC, 16'h0020};
        5:  t = '{'{clrm_8bpp, ximm_1024, pltm_palette, 4'h6},
                  11'd2047, 13'd77, 19'h137FC, 16'h0000};
        6:  t = '{'{clrm_8bpp, ximm_512, pltm_direct, 4'hF},
                  11'd129, 13'd4095, 19'h7FE80, 16'h0003};
        7:  t = '{'{clrm_8bpp, ximm_2048, pltm_direct, 4'h1},
                  11'd2000, 13'd123, 19'h3DFD0, 16'h0000};
        8:  t = '{'{clrm_16bpp, ximm_256, pltm_palette, 4'h7},
                  11'd300, 13'd6000, 19'h6E058, 16'h0100};
        9:  t = '{'{clrm_16bpp, ximm_2048, pltm_direct, 4'h2},
                  11'd2047, 13'd100, 19'h64FFC, 16'h0000};
        10: t = '{'{clrm_2bpp, ximm_1024, pltm_palette, 4'hE},
                  11'd999, 13'd2048, 19'h000F8, 16'h0000};         // Y drops out entirely
        11: t = '{'{clrm_16bpp, ximm_512, pltm_palette, 4'h0},
                  11'd511, 13'd0, 19'h003FC, 16'h8001};
        default: t = '0;
    endcase
    return t;
endfunction

`endif

/* test/bitmap_layer_tb.sv */
`timescale 1ns/1ps

module bitmap_layer_tb
    import bitmap_pkg::*;
();
    localparam int NUM_ROWS   = 12;
    localparam int NUM_DOTS   = 2 * DOTS_PER_BANK;
    localparam int MAX_CYCLES = NUM_ROWS * 80 + 200;

    typedef struct packed {
        bitmap_cfg_t            cfg;
        logic [X_W-1:0]         x;
        logic [Y_W-1:0]         y;
        logic [VRAM_ADDR_W-1:0] addr;
        logic [15:0]            zero_mask;         // Bit i zeroes fetched word i
    } case_t;

    logic                   CLK;
    logic                   RESET_n;
    logic                   hold;
    bitmap_cfg_t            cfg;
    logic [X_W-1:0]         x;
    logic [Y_W-1:0]         y;
    logic                   mem_req;
    mem_rsp_t               mem_rsp;
    logic                   line_start;
    logic                   dot_en;
    logic [VRAM_ADDR_W-1:0] mem_addr;
    pixel_t                 pixel;

    int          errors;
    int          checks;
    int          cycles;
    logic [31:0] lfsr_state;
    logic [31:0] words [16];                       // Raw words of the current line

    `include "bitmap_tb_cases.svh"

    bitmap_layer i_bitmap_layer (.*);

    initial begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            $display("timeout: the run went past %0d cycles without finishing", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
    endfunction

    // One LFSR step per bit of the word
    task automatic next_word(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    function automatic int pixels_per_word(color_mode_e m);
        return 16 >> int'(m);
    endfunction

    function automatic logic [VRAM_ADDR_W-1:0] rule_addr(case_t c);
        int     ppw;
        int     width;
        longint idx;
        ppw   = pixels_per_word(c.cfg.color_mode);
        width = 256 << int'(c.cfg.image_width);
        idx   = longint'(c.y) * (width / ppw) + (int'(c.x) % width) / ppw;
        return VRAM_ADDR_W'((idx * 4) % (longint'(1) << VRAM_ADDR_W));
    endfunction

    function automatic logic [31:0] byte_swap(logic [31:0] w);
        logic [31:0] s;
        for (int i = 0; i < 4; i++) begin
            s[8*(3-i) +: 8] = w[8*i +: 8];
        end
        return s;
    endfunction

    // Dot k of the line sits in bank k/16, at a slot and field within that bank
    function automatic logic [15:0] expected_raw(color_mode_e m, int k);
        int          ppw;
        int          bpp;
        int          pos;
        logic [31:0] w;
        logic [31:0] mask;
        ppw  = pixels_per_word(m);
        bpp  = 32 / ppw;
        pos  = k % DOTS_PER_BANK;
        w    = byte_swap(words[(k / DOTS_PER_BANK) * (DOTS_PER_BANK / ppw) + pos / ppw]);
        mask = (32'd1 << bpp) - 32'd1;
        return 16'((w >> (32 - bpp * (pos % ppw + 1))) & mask);
    endfunction

    function automatic pixel_t expected_pixel(bitmap_cfg_t c, logic [15:0] raw);
        pixel_t p;
        p = '{pri: 1'b1, pa: 6'd0, clr: 16'd0};
        if (c.color_mode == clrm_2bpp) begin
            p.pri = (raw[1:0] == 2'd0);
            p.pa  = {c.plt_offset, raw[1:0]};
        end else if (c.color_mode == clrm_4bpp) begin
            p.pri = (raw[3:0] == 4'd0);
            p.pa  = {c.plt_offset[3:2], raw[3:0]};
        end else if (c.color_mode == clrm_8bpp && c.palette_mode == pltm_palette) begin
            p.pri = (raw[5:0] == 6'd0);
            p.pa  = raw[5:0];
        end else if (c.color_mode == clrm_8bpp) begin
            p.clr = {8'h00, raw[7:0]};
        end else begin
            p.pri = 1'b0;
            p.clr = raw;
        end
        return p;
    endfunction

    task automatic check_pixel(pixel_t exp, string what);
        checks++;
        if (pixel !== exp) begin
            errors++;
            $display("error at %0d ns: %s pixel %h, expected %h", $time, what, pixel, exp);
        end
    endtask

    task automatic check_addr(logic [VRAM_ADDR_W-1:0] exp, string what);
        checks++;
        if (mem_addr !== exp) begin
            errors++;
            $display("error at %0d ns: %s mem_addr %h, expected %h", $time, what, mem_addr, exp);
        end
    endtask

    task automatic run_row(case_t c, int r);
        int          wpb;
        int          hold_at;
        logic [31:0] w;
        pixel_t      exp;
        cfg     = c.cfg;
        x       = c.x;
        y       = c.y;
        mem_req = 1'b1;
        @(negedge CLK);
        mem_req = 1'b0;
        checks++;
        if (c.addr !== rule_addr(c)) begin
            errors++;
            $display("error at %0d ns: row %0d table address %h, rule gives %h",
                     $time, r, c.addr, rule_addr(c));
        end
        check_addr(c.addr, $sformatf("row %0d", r));
        line_start = 1'b1;
        @(negedge CLK);
        line_start = 1'b0;
        wpb = DOTS_PER_BANK / pixels_per_word(c.cfg.color_mode);
        for (int i = 0; i < 2 * wpb; i++) begin
            next_word(w);
            if (c.zero_mask[i]) begin
                w = '0;
            end
            words[i] = w;
            mem_rsp  = '{ack: 1'b1, rdata: w};
            @(negedge CLK);
        end
        mem_rsp = '0;
        repeat (2) @(negedge CLK);                 // Let the last writes land
        dot_en  = 1'b1;
        hold_at = (r * 5) % 28 + 2;
        repeat (4) @(negedge CLK);                 // Three-stage read pipeline
        for (int k = 0; k < NUM_DOTS; k++) begin
            if (k > 0) begin
                @(negedge CLK);
            end
            exp = expected_pixel(c.cfg, expected_raw(c.cfg.color_mode, k));
            check_pixel(exp, $sformatf("row %0d dot %0d", r, k));
            if (k == hold_at) begin
                hold = 1'b1;
                repeat (3 + r % 3) begin
                    @(negedge CLK);
                    check_pixel(exp, $sformatf("row %0d held dot %0d", r, k));
                end
                hold = 1'b0;
            end
        end
        dot_en = 1'b0;
        @(negedge CLK);
    endtask

    initial begin
        RESET_n    = 1'b0;
        hold       = 1'b0;
        cfg        = '0;
        x          = '0;
        y          = '0;
        mem_req    = 1'b0;
        mem_rsp    = '0;
        line_start = 1'b0;
        dot_en     = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        lfsr_state = 32'h87894244;
        repeat (10) @(negedge CLK);
        RESET_n = 1'b1;
        @(negedge CLK);
        check_pixel('{pri: 1'b1, pa: 6'd0, clr: 16'd0}, "after reset");
        check_addr('0, "after reset");
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_row(table_row(r), r);
        end
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* hw/bitmap_layer.sv */
`timescale 1ns/1ps

module bitmap_layer
    import bitmap_pkg::*;
(
    input  logic                   CLK,
    input  logic                   RESET_n,
    input  logic                   hold,
    input  bitmap_cfg_t            cfg,
    input  logic [X_W-1:0]         x,
    input  logic [Y_W-1:0]         y,
    input  logic                   mem_req,
    input  mem_rsp_t               mem_rsp,
    input  logic                   line_start,
    input  logic                   dot_en,
    output logic [VRAM_ADDR_W-1:0] mem_addr,
    output pixel_t                 pixel
);
    localparam int WORDS  = 16;                    // Slots per bank
    localparam int WORD_W = 32;

    logic                     wr_bank;
    logic [$clog2(WORDS)-1:0] wr_slot;
    logic [WORD_W-1:0]        wr_data;
    logic                     wr_strobe;
    logic [RAW_DOT_W-1:0]     raw_dot;

    fetch_addr_gen i_fetch_addr_gen (
        .CLK,
        .RESET_n,
        .hold,
        .color_mode  (cfg.color_mode),
        .image_width (cfg.image_width),
        .x,
        .y,
        .mem_req,
        .mem_addr
    );

    fetch_word_writer i_fetch_word_writer (
        .CLK,
        .RESET_n,
        .hold,
        .color_mode (cfg.color_mode),
        .line_start,
        .mem_rsp,
        .wr_bank,
        .wr_slot,
        .wr_data,
        .wr_strobe
    );

    line_buffer #(
        .WORDS  (WORDS),
        .WORD_W (WORD_W)
    ) i_line_buffer (
        .CLK,
        .RESET_n,
        .hold,
        .color_mode (cfg.color_mode),
        .line_start,
        .dot_en,
        .wr_bank,
        .wr_slot,
        .wr_data,
        .wr_strobe,
        .raw_dot
    );

    pixel_decoder i_pixel_decoder (
        .CLK,
        .RESET_n,
        .hold,
        .dot_en,
        .cfg,
        .raw_dot,
        .pixel
    );

endmodule

/* hw/pixel_decoder.sv */
`timescale 1ns/1ps

module pixel_decoder
    import bitmap_pkg::*;
(
    input  logic                 CLK,
    input  logic                 RESET_n,
    input  logic                 hold,
    input  logic                 dot_en,
    input  bitmap_cfg_t          cfg,
    input  logic [RAW_DOT_W-1:0] raw_dot,
    output pixel_t               pixel
);
    pixel_t dot_next;

    always_comb begin
        dot_next = '{pri: 1'b1, pa: '0, clr: '0};
        case (cfg.color_mode)
            clrm_2bpp: begin
                dot_next.pri = (raw_dot[1:0] == 2'd0);
                dot_next.pa  = {cfg.plt_offset, raw_dot[1:0]};
            end
            clrm_4bpp: begin
                dot_next.pri = (raw_dot[3:0] == 4'd0);
                dot_next.pa  = {cfg.plt_offset[3:2], raw_dot[3:0]};
            end
            clrm_8bpp: begin
                if (cfg.palette_mode == pltm_palette) begin
                    dot_next.pri = (raw_dot[5:0] == 6'd0);   // Top two bits ignored
                    dot_next.pa  = raw_dot[5:0];
                end else begin
                    dot_next.clr = {8'h00, raw_dot[7:0]};
                end
            end
            default: begin                         // 16 bpp direct colour
                dot_next.pri = 1'b0;
                dot_next.clr = raw_dot;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            pixel <= '{pri: 1'b1, pa: '0, clr: '0};
        end else if (!hold && dot_en) begin
            pixel <= dot_next;
        end
    end

endmodule

/* hw/line_buffer.sv */
`timescale 1ns/1ps

module line_buffer
    import bitmap_pkg::*;
#(
    parameter int WORDS  = 16,
    parameter int WORD_W = 32
) (
    input  logic                     CLK,
    input  logic                     RESET_n,
    input  logic                     hold,
    input  color_mode_e              color_mode,
    input  logic                     line_start,
    input  logic                     dot_en,
    input  logic                     wr_bank,
    input  logic [$clog2(WORDS)-1:0] wr_slot,
    input  logic [WORD_W-1:0]        wr_data,
    input  logic                     wr_strobe,
    output logic [RAW_DOT_W-1:0]     raw_dot
);
    localparam int ADDR_W = $clog2(WORDS);
    localparam int POS_W  = $clog2(DOTS_PER_BANK);
    localparam int SH_W   = $clog2(WORD_W);

    logic [1:0]        bank_we;                    // One strobe per bank
    logic [ADDR_W-1:0] wr_slot_q;
    logic [WORD_W-1:0] wr_data_q;
    logic [POS_W-1:0]  rd_pos;
    logic              rd_bank;
    logic [POS_W-1:0]  rd_pos_q;                   // Aligned with RAM output
    logic              rd_bank_q;
    logic [POS_W-1:0]  addr_pos;
    logic [ADDR_W-1:0] rd_addr;
    logic [WORD_W-1:0] rd_word [2];
    logic [WORD_W-1:0] word_sel;
    logic [WORD_W-1:0] word_sh;
    logic [2:0]        ppw_sh;
    logic [POS_W-1:0]  field_mask;
    logic [SH_W-1:0]   shamt;

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            bank_we <= 2'b00;
        end else if (!hold) begin
            bank_we <= wr_strobe ? (wr_bank ? 2'b10 : 2'b01) : 2'b00;
        end
    end

    always_ff @(posedge CLK) begin
        if (!hold && wr_strobe) begin
            wr_slot_q <= wr_slot;
            wr_data_q <= wr_data;
        end
    end

    // Start one before the wrap so the first dot is bank 0, position 0
    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            rd_pos    <= '0;
            rd_bank   <= 1'b0;
            rd_pos_q  <= '0;
            rd_bank_q <= 1'b0;
        end else if (!hold) begin
            rd_pos_q  <= rd_pos;
            rd_bank_q <= rd_bank;
            if (line_start) begin
                rd_pos  <= '1;
                rd_bank <= 1'b1;
            end else if (dot_en) begin
                rd_pos <= rd_pos + 1'b1;
                if (rd_pos == '1) begin
                    rd_bank <= !rd_bank;
                end
            end
        end
    end

    // Under hold the RAM re-reads the word already on its output
    always_comb begin
        ppw_sh   = ppw_log2(color_mode);
        addr_pos = hold ? rd_pos_q : rd_pos;
        rd_addr  = ADDR_W'(addr_pos >> ppw_sh);
    end

    for (genvar b = 0; b < 2; b++) begin : g_bank
        line_ram #(
            .WORDS  (WORDS),
            .WORD_W (WORD_W)
        ) i_line_ram (
            .CLK,
            .wr_en   (bank_we[b] && !hold),
            .wr_addr (wr_slot_q),
            .wr_data (wr_data_q),
            .rd_addr,
            .rd_data (rd_word[b])
        );
    end

    // Fields count from the MSB, so shift the wanted one to the top
    always_comb begin
        word_sel   = rd_bank_q ? rd_word[1] : rd_word[0];
        field_mask = (POS_W'(1) << ppw_sh) - 1'b1; // 2 bpp wraps to all ones
        shamt      = SH_W'(rd_pos_q & field_mask) << (3'(color_mode) + 3'd1);
        word_sh    = word_sel << shamt;
    end

    always_ff @(posedge CLK) begin
        if (!hold) begin
            case (color_mode)
                clrm_2bpp:  raw_dot <= RAW_DOT_W'(word_sh[WORD_W-1 -: 2]);
                clrm_4bpp:  raw_dot <= RAW_DOT_W'(word_sh[WORD_W-1 -: 4]);
                clrm_8bpp:  raw_dot <= RAW_DOT_W'(word_sh[WORD_W-1 -: 8]);
                default:    raw_dot <= word_sh[WORD_W-1 -: RAW_DOT_W];
            endcase
        end
    end

endmodule

/* hw/fetch_word_writer.sv */
`timescale 1ns/1ps

module fetch_word_writer
    import bitmap_pkg::*;
(
    input  logic                               CLK,
    input  logic                               RESET_n,
    input  logic                               hold,
    input  color_mode_e                        color_mode,
    input  logic                               line_start,
    input  mem_rsp_t                           mem_rsp,
    output logic                               wr_bank,
    output logic [$clog2(DOTS_PER_BANK)-1:0]   wr_slot,
    output logic [31:0]                        wr_data,
    output logic                               wr_strobe
);
    localparam int SLOT_W = $clog2(DOTS_PER_BANK);

    logic [SLOT_W-1:0] idx;                        // Fetch order within two banks
    logic [SLOT_W-1:0] cur_idx;
    logic [SLOT_W-1:0] slot_mask;
    logic [SLOT_W-1:0] wrap_mask;
    logic [1:0]        wpb_sh;

    always_comb begin
        wpb_sh    = 2'(color_mode);                // log2 words per bank
        cur_idx   = line_start ? '0 : idx;         // Ack with line_start goes to slot 0
        slot_mask = (SLOT_W'(1) << wpb_sh) - 1'b1;
        // 16 bpp overflows to zero here and wraps to all ones
        wrap_mask = (SLOT_W'(2) << wpb_sh) - 1'b1;
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            idx       <= '0;
            wr_bank   <= 1'b0;
            wr_slot   <= '0;
            wr_strobe <= 1'b0;
        end else if (!hold) begin
            wr_strobe <= mem_rsp.ack;
            if (mem_rsp.ack) begin
                wr_bank <= cur_idx[wpb_sh];
                wr_slot <= cur_idx & slot_mask;
                idx     <= (cur_idx + 1'b1) & wrap_mask;
            end else if (line_start) begin
                idx <= '0;
            end
        end
    end

    // Memory byte 0 ends up in the top byte
    always_ff @(posedge CLK) begin
        if (!hold && mem_rsp.ack) begin
            wr_data <= {mem_rsp.rdata[7:0], mem_rsp.rdata[15:8],
                        mem_rsp.rdata[23:16], mem_rsp.rdata[31:24]};
        end
    end

endmodule

/* hw/fetch_addr_gen.sv */
`timescale 1ns/1ps

module fetch_addr_gen
    import bitmap_pkg::*;
(
    input  logic                   CLK,
    input  logic                   RESET_n,
    input  logic                   hold,
    input  color_mode_e            color_mode,
    input  image_width_e           image_width,
    input  logic [X_W-1:0]         x,
    input  logic [Y_W-1:0]         y,
    input  logic                   mem_req,
    output logic [VRAM_ADDR_W-1:0] mem_addr
);
    localparam int WIDX_W = VRAM_ADDR_W - 2;      // 32-bit word index

    logic [2:0]        ppw_sh;
    logic [3:0]        wpl_sh;
    logic [X_W-1:0]    x_word;
    logic [WIDX_W-1:0] x_mask;
    logic [WIDX_W-1:0] word_idx;

    // Depth x width table folded into shifts:
    // the x field is x[log2(width)-1 : log2(ppw)], y fills the bits above it
    always_comb begin
        ppw_sh   = ppw_log2(color_mode);
        wpl_sh   = 4'd8 + 4'(image_width) - 4'(ppw_sh);   // log2 words per line
        x_word   = x >> ppw_sh;                            // Word column
        x_mask   = (WIDX_W'(1) << wpl_sh) - 1'b1;          // Drop bits past the width
        word_idx = (WIDX_W'(y) << wpl_sh) | (WIDX_W'(x_word) & x_mask);
    end

    always_ff @(posedge CLK or negedge RESET_n) begin
        if (!RESET_n) begin
            mem_addr <= '0;
        end else if (!hold && mem_req) begin
            mem_addr <= {word_idx, 2'b00};         // Upper y bits fall off here
        end
    end

endmodule

/* hw/line_ram.sv */
`timescale 1ns/1ps

module line_ram #(
    parameter int WORDS  = 16,
    parameter int WORD_W = 32
) (
    input  logic                     CLK,
    input  logic                     wr_en,
    input  logic [$clog2(WORDS)-1:0] wr_addr,
    input  logic [WORD_W-1:0]        wr_data,
    input  logic [$clog2(WORDS)-1:0] rd_addr,
    output logic [WORD_W-1:0]        rd_data
);
    logic [WORD_W-1:0] mem [WORDS];

    always_ff @(posedge CLK) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        rd_data <= mem[rd_addr];                   // Registered read, block RAM style
    end

endmodule

/* hw/bitmap_pkg.sv */
package bitmap_pkg;

    localparam int VRAM_ADDR_W   = 19;             // Byte address into VRAM
    localparam int X_W           = 11;
    localparam int Y_W           = 13;
    localparam int DOTS_PER_BANK = 16;
    localparam int RAW_DOT_W     = 16;             // Widest dot, 16 bpp

    typedef enum logic [1:0] {
        clrm_2bpp  = 2'd0,
        clrm_4bpp  = 2'd1,
        clrm_8bpp  = 2'd2,
        clrm_16bpp = 2'd3
    } color_mode_e;

    typedef enum logic [1:0] {
        ximm_256  = 2'd0,
        ximm_512  = 2'd1,
        ximm_1024 = 2'd2,
        ximm_2048 = 2'd3
    } image_width_e;

    typedef enum logic {
        pltm_palette = 1'b0,
        pltm_direct  = 1'b1
    } palette_mode_e;

    typedef struct packed {
        color_mode_e   color_mode;
        image_width_e  image_width;
        palette_mode_e palette_mode;
        logic [3:0]    plt_offset;                 // Upper palette bits, 2/4 bpp
    } bitmap_cfg_t;

    typedef struct packed {
        logic        pri;                          // Transparent dot
        logic [5:0]  pa;
        logic [15:0] clr;
    } pixel_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] rdata;
    } mem_rsp_t;

    // log2 of the pixels held in one 32-bit word
    function automatic logic [2:0] ppw_log2(color_mode_e mode);
        return 3'd4 - 3'(mode);
    endfunction

endpackage
